//--- design/tmr_mem_pkg.sv
`default_nettype none

package tmr_mem_pkg;

  ////////////////////
  // Sizes
  ////////////////////
  localparam int ADDR_W     = 8;
  localparam int DATA_W     = 8;
  localparam int NUM_COPIES = 3;
  localparam int CNT_W      = 16;
  localparam int APB_ADDR_W = 12;
  localparam int MEM_DEPTH  = 1 << ADDR_W;

  // Grant bit positions on the arbiter output
  localparam int GNT_REPAIR = 0;
  localparam int GNT_HOST   = 1;
  localparam int GNT_SCRUB  = 2;

  ////////////////////
  // APB address map
  ////////////////////
  localparam int REGION_LSB   = 10;
  localparam int COPY_SEL_LSB = 8;

  typedef enum logic [1:0] {
    REGION_DATA = 2'd0,
    REGION_COPY = 2'd1,
    REGION_STAT = 2'd2,
    REGION_ERR  = 2'd3
  } region_e;

  typedef logic [NUM_COPIES-1:0] copy_mask_t;

  localparam copy_mask_t FULL_MASK = '1;

  ////////////////////
  // Memory request and response
  ////////////////////
  typedef struct packed {
    logic              valid;
    logic              write;
    copy_mask_t        mask;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- design/sram_bank.sv
`default_nettype none
`timescale 1ns/1ps

module sram_bank (
  input  logic                             clk,
  input  logic                             rst,
  input  tmr_mem_pkg::mem_req_t            req,
  input  logic                             write_en,
  output logic [tmr_mem_pkg::DATA_W-1:0]   rdata
);

  logic [tmr_mem_pkg::DATA_W-1:0] mem [tmr_mem_pkg::MEM_DEPTH];
  logic                           do_write;
  logic                           do_read;

  // Own mask bit decides whether this copy takes the write
  assign do_write = req.valid && req.write && write_en;
  assign do_read  = req.valid && !req.write;

  // Byte array
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[req.addr] <= req.wdata;
    end
  end

  // One-cycle registered read port
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdata <= '0;
    end else if (do_read) begin
      rdata <= mem[req.addr];
    end
  end

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module mem_arbiter #(
  parameter type req_t = tmr_mem_pkg::mem_req_t
) (
  input  logic       clk,
  input  logic       rst,
  input  req_t       repair_req,
  input  req_t       host_req,
  input  req_t       scrub_req,
  output logic [2:0] grant,
  output req_t       bank_req
);

  logic read_last;
  logic repair_ok;
  logic host_ok;
  logic scrub_ok;

  // Reads are held off for one cycle after a granted read
  always_comb begin
    repair_ok = repair_req.valid && !(read_last && !repair_req.write);
    host_ok   = host_req.valid && !(read_last && !host_req.write);
    scrub_ok  = scrub_req.valid && !(read_last && !scrub_req.write);
  end

  ////////////////////
  // Fixed priority: repair, host, scrub
  ////////////////////
  always_comb begin
    grant    = '0;
    bank_req = '0;
    if (repair_ok) begin
      grant[tmr_mem_pkg::GNT_REPAIR] = 1'b1;
      bank_req                       = repair_req;
    end else if (host_ok) begin
      grant[tmr_mem_pkg::GNT_HOST] = 1'b1;
      bank_req                     = host_req;
    end else if (scrub_ok) begin
      grant[tmr_mem_pkg::GNT_SCRUB] = 1'b1;
      bank_req                      = scrub_req;
    end
  end

  // Remember a read went out this cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      read_last <= 1'b0;
    end else begin
      read_last <= bank_req.valid && !bank_req.write;
    end
  end

endmodule

`default_nettype wire

//--- design/tmr_voter.sv
`default_nettype none
`timescale 1ns/1ps

module tmr_voter (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [tmr_mem_pkg::DATA_W-1:0]   rdata_0,
  input  logic [tmr_mem_pkg::DATA_W-1:0]   rdata_1,
  input  logic [tmr_mem_pkg::DATA_W-1:0]   rdata_2,
  input  tmr_mem_pkg::mem_req_t            bank_req,
  input  logic                             repair_grant,
  output tmr_mem_pkg::mem_req_t            repair_req,
  output tmr_mem_pkg::mem_rsp_t            rsp,
  output logic [tmr_mem_pkg::CNT_W-1:0]    repair_count,
  input  logic                             count_clear
);

  logic                           rd_pending_q;
  logic [tmr_mem_pkg::ADDR_W-1:0] rd_addr_q;
  logic [tmr_mem_pkg::DATA_W-1:0] voted;
  logic                           mismatch;
  logic                           write_hit;
  logic                           repair_valid_q;
  logic [tmr_mem_pkg::ADDR_W-1:0] repair_addr_q;
  logic [tmr_mem_pkg::DATA_W-1:0] repair_data_q;
  logic                           repair_fire;

  // Track which cycle carries bank read data
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_pending_q <= 1'b0;
    end else begin
      rd_pending_q <= bank_req.valid && !bank_req.write;
    end
  end

  always_ff @(posedge clk) begin
    if (bank_req.valid && !bank_req.write) begin
      rd_addr_q <= bank_req.addr;
    end
  end

  ////////////////////
  // Bitwise 2-of-3 vote
  ////////////////////
  assign voted = (rdata_0 & rdata_1) | (rdata_0 & rdata_2) | (rdata_1 & rdata_2);

  assign mismatch = rd_pending_q &&
                    ((rdata_0 != voted) || (rdata_1 != voted) || (rdata_2 != voted));

  // A write landing on the same byte now makes the voted value stale
  assign write_hit = bank_req.valid && bank_req.write && (bank_req.addr == rd_addr_q);

  assign repair_fire = repair_grant && repair_valid_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      repair_valid_q <= 1'b0;
    end else if (mismatch && !write_hit) begin
      repair_valid_q <= 1'b1;
    end else if (repair_fire) begin
      repair_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (mismatch) begin
      repair_addr_q <= rd_addr_q;
      repair_data_q <= voted;
    end
  end

  // Repair rewrites every copy
  always_comb begin
    repair_req.valid = repair_valid_q;
    repair_req.write = 1'b1;
    repair_req.mask  = tmr_mem_pkg::FULL_MASK;
    repair_req.addr  = repair_addr_q;
    repair_req.wdata = repair_data_q;
  end

  assign rsp.valid = rd_pending_q;
  assign rsp.data  = voted;

  // Saturating repair counter, clear wins
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      repair_count <= '0;
    end else if (count_clear) begin
      repair_count <= '0;
    end else if (repair_fire && (repair_count != '1)) begin
      repair_count <= repair_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/scrub_engine.sv
`default_nettype none
`timescale 1ns/1ps

module scrub_engine #(
  parameter int SCRUB_INTERVAL = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  grant,
  output tmr_mem_pkg::mem_req_t scrub_req
);

  localparam int WAIT_W = (SCRUB_INTERVAL > 1) ? $clog2(SCRUB_INTERVAL) : 1;

  logic [WAIT_W-1:0]              wait_cnt;
  logic                           req_valid;
  logic [tmr_mem_pkg::ADDR_W-1:0] scrub_addr;

  ////////////////////
  // Interval and address walk
  ////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wait_cnt   <= '0;
      req_valid  <= 1'b0;
      scrub_addr <= '0;
    end else if (req_valid) begin
      // Hold until granted, then move on
      if (grant) begin
        req_valid  <= 1'b0;
        wait_cnt   <= '0;
        scrub_addr <= scrub_addr + 1'b1;
      end
    end else if (wait_cnt == WAIT_W'(SCRUB_INTERVAL - 1)) begin
      req_valid <= 1'b1;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // Always a full read of all copies
  always_comb begin
    scrub_req.valid = req_valid;
    scrub_req.write = 1'b0;
    scrub_req.mask  = tmr_mem_pkg::FULL_MASK;
    scrub_req.addr  = scrub_addr;
    scrub_req.wdata = '0;
  end

endmodule

`default_nettype wire

//--- design/apb_mem_port.sv
`default_nettype none
`timescale 1ns/1ps

module apb_mem_port (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [tmr_mem_pkg::APB_ADDR_W-1:0]  paddr,
  input  logic [tmr_mem_pkg::DATA_W-1:0]      pwdata,
  output logic [tmr_mem_pkg::DATA_W-1:0]      prdata,
  output logic                                pready,
  output logic                                pslverr,
  output tmr_mem_pkg::mem_req_t               host_req,
  input  logic                                grant,
  input  tmr_mem_pkg::mem_rsp_t               rsp,
  input  logic [tmr_mem_pkg::CNT_W-1:0]       repair_count,
  output logic                                count_clear
);

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_DONE} state_e;
  typedef enum logic [2:0] {OP_MEM_RD, OP_MEM_WR, OP_STAT_RD, OP_STAT_WR, OP_ERR} op_e;

  state_e                         state;
  op_e                            op_d;
  op_e                            op_q;
  tmr_mem_pkg::region_e           region;
  logic [1:0]                     copy_sel;
  logic                           setup;
  tmr_mem_pkg::copy_mask_t        mask_d;
  tmr_mem_pkg::copy_mask_t        mask_q;
  logic [tmr_mem_pkg::ADDR_W-1:0] addr_q;
  logic [tmr_mem_pkg::DATA_W-1:0] wdata_q;
  logic                           hi_q;

  assign setup    = psel && !penable;
  assign region   = tmr_mem_pkg::region_e'(paddr[tmr_mem_pkg::REGION_LSB +: 2]);
  assign copy_sel = paddr[tmr_mem_pkg::COPY_SEL_LSB +: 2];

  ////////////////////
  // Address decode
  ////////////////////
  always_comb begin
    op_d   = OP_ERR;
    mask_d = tmr_mem_pkg::FULL_MASK;
    case (region)
      tmr_mem_pkg::REGION_DATA: op_d = pwrite ? OP_MEM_WR : OP_MEM_RD;
      tmr_mem_pkg::REGION_COPY: begin
        // Single-copy writes only, select 3 is illegal
        if (pwrite && (copy_sel < tmr_mem_pkg::NUM_COPIES)) begin
          op_d   = OP_MEM_WR;
          mask_d = tmr_mem_pkg::copy_mask_t'(1 << copy_sel);
        end
      end
      tmr_mem_pkg::REGION_STAT: op_d = pwrite ? OP_STAT_WR : OP_STAT_RD;
      default: op_d = OP_ERR;
    endcase
  end

  ////////////////////
  // Transfer FSM
  ////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ST_IDLE;
      op_q  <= OP_ERR;
    end else begin
      case (state)
        ST_IDLE: begin
          if (setup) begin
            op_q  <= op_d;
            state <= (op_d == OP_MEM_RD || op_d == OP_MEM_WR) ? ST_REQ : ST_DONE;
          end
        end
        ST_REQ: begin
          if (grant) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (pready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Request payload captured in the setup cycle
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && setup) begin
      mask_q  <= mask_d;
      addr_q  <= paddr[tmr_mem_pkg::ADDR_W-1:0];
      wdata_q <= pwdata;
      hi_q    <= paddr[0];
    end
  end

  always_comb begin
    host_req.valid = (state == ST_REQ);
    host_req.write = (op_q == OP_MEM_WR);
    host_req.mask  = mask_q;
    host_req.addr  = addr_q;
    host_req.wdata = wdata_q;
  end

  // Data reads finish with the voted response
  assign pready = psel && penable && (state == ST_DONE) &&
                  ((op_q != OP_MEM_RD) || rsp.valid);
  assign pslverr     = pready && (op_q == OP_ERR);
  assign count_clear = pready && (op_q == OP_STAT_WR);

  always_comb begin
    case (op_q)
      OP_MEM_RD:  prdata = rsp.data;
      OP_STAT_RD: prdata = hi_q ? repair_count[15:8] : repair_count[7:0];
      default:    prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/tmr_sram_top.sv
`default_nettype none
`timescale 1ns/1ps

module tmr_sram_top #(
  parameter int SCRUB_INTERVAL = 16
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [tmr_mem_pkg::APB_ADDR_W-1:0]  paddr,
  input  logic [tmr_mem_pkg::DATA_W-1:0]      pwdata,
  output logic [tmr_mem_pkg::DATA_W-1:0]      prdata,
  output logic                                pready,
  output logic                                pslverr
);

  tmr_mem_pkg::mem_req_t          host_req;
  tmr_mem_pkg::mem_req_t          scrub_req;
  tmr_mem_pkg::mem_req_t          repair_req;
  tmr_mem_pkg::mem_req_t          bank_req;
  tmr_mem_pkg::mem_rsp_t          rsp;
  logic [2:0]                     grant;
  logic                           repair_grant;
  logic                           host_grant;
  logic                           scrub_grant;
  logic [tmr_mem_pkg::CNT_W-1:0]  repair_count;
  logic                           count_clear;
  logic [tmr_mem_pkg::DATA_W-1:0] bank_rdata [tmr_mem_pkg::NUM_COPIES];

  assign repair_grant = grant[tmr_mem_pkg::GNT_REPAIR];
  assign host_grant   = grant[tmr_mem_pkg::GNT_HOST];
  assign scrub_grant  = grant[tmr_mem_pkg::GNT_SCRUB];

  ////////////////////
  // Requesters
  ////////////////////
  apb_mem_port u_apb (
    .clk(clk), .rst(rst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .host_req(host_req), .grant(host_grant), .rsp(rsp),
    .repair_count(repair_count), .count_clear(count_clear)
  );

  scrub_engine #(.SCRUB_INTERVAL(SCRUB_INTERVAL)) u_scrub (
    .clk(clk), .rst(rst), .grant(scrub_grant), .scrub_req(scrub_req)
  );

  mem_arbiter #(.req_t(tmr_mem_pkg::mem_req_t)) u_arb (
    .clk(clk), .rst(rst),
    .repair_req(repair_req), .host_req(host_req), .scrub_req(scrub_req),
    .grant(grant), .bank_req(bank_req)
  );

  ////////////////////
  // Banks and vote
  ////////////////////
  for (genvar i = 0; i < tmr_mem_pkg::NUM_COPIES; i++) begin : g_bank
    sram_bank u_bank (
      .clk(clk), .rst(rst), .req(bank_req),
      .write_en(bank_req.mask[i]), .rdata(bank_rdata[i])
    );
  end

  tmr_voter u_voter (
    .clk(clk), .rst(rst),
    .rdata_0(bank_rdata[0]), .rdata_1(bank_rdata[1]), .rdata_2(bank_rdata[2]),
    .bank_req(bank_req), .repair_grant(repair_grant), .repair_req(repair_req),
    .rsp(rsp), .repair_count(repair_count), .count_clear(count_clear)
  );

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release lands just after a rising edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- tb/tmr_sram_properties.sv
`default_nettype none
`timescale 1ns/1ps

module tmr_sram_properties (
  input logic                                clk,
  input logic                                rst,
  input logic [2:0]                          grant,
  input tmr_mem_pkg::mem_req_t               bank_req,
  input logic                                psel,
  input logic                                penable,
  input logic [tmr_mem_pkg::APB_ADDR_W-1:0]  paddr,
  input logic                                pready
);

  logic read_gnt;
  logic data_region;

  assign read_gnt    = bank_req.valid && !bank_req.write;
  assign data_region = (paddr[tmr_mem_pkg::REGION_LSB +: 2] == tmr_mem_pkg::REGION_DATA);

  ////////////////////
  // Arbiter
  ////////////////////
  a_read_spacing: assert property (@(posedge clk) disable iff (rst)
    !(read_gnt && $past(read_gnt)))
    else $error("read granted on two consecutive cycles");

  a_one_grant: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("more than one grant bit high, grant=0x%0h", grant);

  ////////////////////
  // APB port
  ////////////////////
  // Data reads and writes end one cycle after the host grant
  a_data_ready_timing: assert property (@(posedge clk) disable iff (rst)
    (pready && psel && penable && data_region) |-> $past(grant[tmr_mem_pkg::GNT_HOST]))
    else $error("data access ended without a host grant in the previous cycle");

  // Quiet through reset and the first cycle after it
  a_ready_after_reset: assert property (@(posedge clk) (rst || $past(rst)) |-> !pready)
    else $error("pready high during or right after reset");

endmodule

bind tmr_sram_top tmr_sram_properties u_props (
  .clk(clk), .rst(rst), .grant(grant), .bank_req(bank_req),
  .psel(psel), .penable(penable), .paddr(paddr), .pready(pready)
);

`default_nettype wire

//--- tb/tmr_sram_tb.sv
`default_nettype none
`timescale 1ns/1ps

module tmr_sram_tb;

  localparam int SCRUB_INTERVAL = 16;
  localparam int READY_TIMEOUT  = 50;
  localparam int SCRUB_SWEEP    = 256 * (SCRUB_INTERVAL + 4);

  // One APB transfer, or an idle stretch when idle is nonzero
  typedef struct packed {
    logic        write;
    logic [11:0] paddr;
    logic [7:0]  wdata;
    logic        check_data;
    logic [7:0]  exp_data;
    logic        exp_err;
    logic [15:0] idle;
  } step_t;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [7:0]  pwdata;
  logic [7:0]  prdata;
  logic        pready;
  logic        pslverr;

  step_t       steps[$];
  logic [7:0]  copies [3][256];
  int          exp_count;
  int          checks;
  int          errors;
  int          test_num;

  tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(3)) u_clk (.clk(clk), .rst(rst));

  tmr_sram_top #(.SCRUB_INTERVAL(SCRUB_INTERVAL)) DUT (
    .clk(clk), .rst(rst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  ////////////////////
  // Reference model
  ////////////////////
  function automatic logic [7:0] majority(input logic [7:0] a, input logic [7:0] b,
                                          input logic [7:0] c);
    logic [7:0] m;
    for (int i = 0; i < 8; i++) begin
      m[i] = (32'(a[i]) + 32'(b[i]) + 32'(c[i])) > 32'd1;
    end
    return m;
  endfunction

  // Any disagreeing copy costs one repair
  function automatic logic [7:0] vote_and_repair(input logic [7:0] addr);
    logic [7:0] voted;
    voted = majority(copies[0][addr], copies[1][addr], copies[2][addr]);
    if (copies[0][addr] != voted || copies[1][addr] != voted || copies[2][addr] != voted) begin
      if (exp_count < 32'hFFFF) exp_count++;
    end
    for (int c = 0; c < 3; c++) copies[c][addr] = voted;
    return voted;
  endfunction

  function automatic void push_step(input logic wr, input logic [11:0] addr,
                                    input logic [7:0] wdata, input logic chk,
                                    input logic [7:0] exp, input logic err);
    step_t s;
    s.write      = wr;
    s.paddr      = addr;
    s.wdata      = wdata;
    s.check_data = chk;
    s.exp_data   = exp;
    s.exp_err    = err;
    s.idle       = '0;
    steps.push_back(s);
  endfunction

  ////////////////////
  // Table builders
  ////////////////////
  function automatic void data_write(input logic [7:0] addr, input logic [7:0] data);
    for (int c = 0; c < 3; c++) copies[c][addr] = data;
    push_step(1'b1, {tmr_mem_pkg::REGION_DATA, 2'b00, addr}, data, 1'b0, 8'h00, 1'b0);
  endfunction

  function automatic void copy_write(input logic [1:0] sel, input logic [7:0] addr,
                                     input logic [7:0] data);
    if (sel != 2'd3) copies[sel][addr] = data;
    push_step(1'b1, {tmr_mem_pkg::REGION_COPY, sel, addr}, data, 1'b0, 8'h00, sel == 2'd3);
  endfunction

  function automatic void data_read(input logic [7:0] addr);
    logic [7:0] voted;
    voted = vote_and_repair(addr);
    push_step(1'b0, {tmr_mem_pkg::REGION_DATA, 2'b00, addr}, 8'h00, 1'b1, voted, 1'b0);
  endfunction

  function automatic void stat_read();
    logic [15:0] cnt;
    cnt = 16'(exp_count);
    push_step(1'b0, {tmr_mem_pkg::REGION_STAT, 10'h000}, 8'h00, 1'b1, cnt[7:0], 1'b0);
    push_step(1'b0, {tmr_mem_pkg::REGION_STAT, 10'h001}, 8'h00, 1'b1, cnt[15:8], 1'b0);
  endfunction

  function automatic void stat_write();
    exp_count = 0;
    push_step(1'b1, {tmr_mem_pkg::REGION_STAT, 10'h000}, 8'h5A, 1'b0, 8'h00, 1'b0);
  endfunction

  function automatic void err_access(input logic wr, input logic [7:0] addr,
                                     input logic [7:0] data);
    push_step(wr, {tmr_mem_pkg::REGION_ERR, 2'b00, addr}, data, 1'b0, 8'h00, 1'b1);
  endfunction

  // Long enough for the scrubber to visit every byte
  function automatic void scrub_idle(input int cycles);
    step_t s;
    for (int a = 0; a < 256; a++) void'(vote_and_repair(8'(a)));
    s      = '0;
    s.idle = 16'(cycles);
    steps.push_back(s);
  endfunction

  ////////////////////
  // APB driver
  ////////////////////
  task automatic apb_xfer(input step_t s, output logic [7:0] rdata, output logic err,
                          output logic done);
    int waited;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = s.write;
    paddr   = s.paddr;
    pwdata  = s.wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    done    = 1'b0;
    rdata   = '0;
    err     = 1'b0;
    waited  = 0;
    // Sample mid-cycle where outputs have settled
    while (!done && waited < READY_TIMEOUT) begin
      @(negedge clk);
      if (pready) begin
        rdata = prdata;
        err   = pslverr;
        done  = 1'b1;
      end else begin
        waited++;
      end
    end
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic run_steps(input string name);
    step_t      s;
    logic [7:0] rdata;
    logic       err;
    logic       done;
    int         errs_before;
    errs_before = errors;
    foreach (steps[i]) begin
      s = steps[i];
      if (s.idle != '0) begin
        repeat (int'(s.idle)) @(posedge clk);
        #2;
      end else begin
        apb_xfer(s, rdata, err, done);
        checks++;
        assert (done) else begin
          $display("Test %0d: no pready within %0d cycles for paddr 0x%03h",
                   test_num, READY_TIMEOUT, s.paddr);
          errors++;
        end
        if (done) begin
          checks++;
          assert (err == s.exp_err) else begin
            $display("[ERROR] pslverr paddr=0x%03h got 0x%0h expected 0x%0h",
                     s.paddr, err, s.exp_err);
            errors++;
          end
          if (s.check_data) begin
            checks++;
            assert (rdata == s.exp_data) else begin
              $display("[ERROR] prdata paddr=0x%03h got 0x%02h expected 0x%02h",
                       s.paddr, rdata, s.exp_data);
              errors++;
            end
          end
        end
      end
    end
    $display("Test %0d %s: %0d steps, %0d errors", test_num, name, steps.size(),
             errors - errs_before);
    steps.delete();
    test_num++;
  endtask

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin
    logic [7:0] a;
    logic [7:0] d;
    logic [7:0] list [24];
    int         waited;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    exp_count = 0;
    checks    = 0;
    errors    = 0;
    test_num  = 1;
    waited    = 0;
    void'($urandom(95381));

    @(posedge clk);
    while (rst && waited < 10) begin
      @(posedge clk);
      waited++;
    end
    #2;
    assert (!rst) else begin
      $display("Reset was never released");
      errors++;
    end

    // Known contents everywhere, then a clean counter
    for (int i = 0; i < 256; i++) data_write(8'(i), 8'(i * 37 + 11));
    stat_write();
    for (int i = 0; i < 16; i++) begin
      list[i] = 8'($urandom);
      data_write(list[i], 8'($urandom));
    end
    for (int i = 0; i < 16; i++) data_read(list[i]);
    run_steps("normal access");

    a = 8'($urandom);
    d = 8'($urandom);
    data_write(a, d);
    copy_write(2'd1, a, d ^ 8'hA5);
    data_read(a);
    stat_read();
    data_read(a);
    stat_read();
    run_steps("single-copy correction");

    // Four faults spread over the copies
    a = 8'($urandom);
    for (int i = 0; i < 4; i++) begin
      list[i] = a + 8'(i * 61);
      copy_write(2'(i % 3), list[i], copies[i % 3][list[i]] ^ 8'h3C);
    end
    scrub_idle(SCRUB_SWEEP);
    stat_read();
    for (int i = 0; i < 4; i++) data_read(list[i]);
    stat_read();
    run_steps("scrub repair");

    stat_write();
    stat_read();
    run_steps("counter clear");

    a = 8'($urandom);
    err_access(1'b0, a, 8'h00);
    err_access(1'b1, a, 8'h99);
    copy_write(2'd3, a, ~copies[0][a]);
    data_read(a);
    stat_read();
    run_steps("error responses");

    a = 8'($urandom);
    copy_write(2'd2, a, copies[2][a] ^ 8'h81);
    for (int i = 0; i < 24; i++) list[i] = (i == 12) ? a : 8'($urandom);
    for (int i = 0; i < 24; i++) data_read(list[i]);
    stat_read();
    run_steps("back-pressure");

    $display("Tests %0d, checks %0d, errors %0d", test_num - 1, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
design/tmr_mem_pkg.sv
design/sram_bank.sv
design/mem_arbiter.sv
design/tmr_voter.sv
design/scrub_engine.sv
design/apb_mem_port.sv
design/tmr_sram_top.sv
tb/tb_clock_gen.sv
tb/tmr_sram_properties.sv
tb/tmr_sram_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the TMR SRAM testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tmr_sram_tb \
  -f flist.f \
  -o tmr_sram_sim

./obj_dir/tmr_sram_sim | tee "$LOG"

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
  echo "Simulation result: pass"
else
  echo "Simulation result: fail"
  exit 1
fi
